/* verilog/rename_pkg.sv */
`default_nettype none

// Shared widths, types and bundles for the register rename block
package rename_pkg;

   // ==================================================================
   // Sizes
   // ==================================================================

   localparam int ARCH_REGS = 32;                  // Architectural registers seen by software
   localparam int PREGS     = 64;                  // Physical registers behind the rename map
   localparam int NCHECK    = 8;                   // Checkpoint slots, one per unresolved branch

   // Field widths follow from the sizes above
   localparam int ARCH_BITS = $clog2(ARCH_REGS);   // 5 bits for an architectural register
   localparam int PREG_BITS = $clog2(PREGS);       // 6 bits for a physical register
   localparam int NDX_BITS  = $clog2(NCHECK);      // Slot index wraps naturally, NCHECK is 2**n
   localparam int CNT_BITS  = $clog2(NCHECK + 1);  // Count must reach NCHECK itself

   // ==================================================================
   // Vector types
   // ==================================================================

   typedef logic [ARCH_BITS-1:0] arch_reg_t;       // Architectural register number
   typedef logic [PREG_BITS-1:0] preg_t;           // Physical register number
   typedef logic [NDX_BITS-1:0]  checkpt_ndx_t;    // Checkpoint slot index
   typedef logic [CNT_BITS-1:0]  checkpt_cnt_t;    // Live checkpoints, 0 to NCHECK

   // The whole rename map, one physical register per architectural register.
   // Entry i is selected with map[i] and is a preg_t
   typedef preg_t [ARCH_REGS-1:0] reg_map_t;

   // ==================================================================
   // Request and response bundles
   // ==================================================================

   // One instruction per cycle enters rename with this bundle
   typedef struct packed {
      arch_reg_t src_a;                            // First source operand
      arch_reg_t src_b;                            // Second source operand
      arch_reg_t dst;                              // Destination, meaningful when has_dst is set
      logic      has_dst;                          // Instruction writes a register
      preg_t     new_preg;                         // Fresh register from the free list
   } rename_req_t;

   // Lookup results, all taken from the map before this cycle's update
   typedef struct packed {
      preg_t src_a_preg;                           // Where src_a currently lives
      preg_t src_b_preg;                           // Where src_b currently lives
      preg_t old_preg;                             // Previous home of dst, freed at retire
   } rename_rsp_t;

endpackage

`default_nettype wire

/* verilog/reg_map_ram.sv */
`default_nettype none

// Checkpoint storage for the rename map.
// Port A writes a whole map into one slot at the clock edge, port B reads
// a slot back with no latency, the way a distributed RAM behaves
module reg_map_ram (
   input  logic                     clka,
   input  logic                     wr_en,     // Port A write strobe
   input  rename_pkg::checkpt_ndx_t wr_ndx,    // Port A slot
   input  rename_pkg::reg_map_t     wr_map,    // Map to be saved
   input  rename_pkg::checkpt_ndx_t rd_ndx,    // Port B slot
   output rename_pkg::reg_map_t     rd_map     // Saved map, available in the same cycle
);

   import rename_pkg::*;

   // ==================================================================
   // Storage array
   // ==================================================================

   // One full map per checkpoint slot
   reg_map_t mem [NCHECK];

   // Synchronous write on port A.
   // A slot is only written by a granted save, so contents are only
   // meaningful for slots that the controller holds as live
   always_ff @(posedge clka) begin
      if (wr_en) begin
         mem[wr_ndx] <= wr_map;
      end
   end

   // ==================================================================
   // Read port
   // ==================================================================

   // Asynchronous read on port B, used by restore.
   // Restore and save never land in the same cycle, so there is no
   // write-through path to worry about here
   always_comb begin
      rd_map = mem[rd_ndx];                    // Pure lookup, no output register
   end

endmodule

`default_nettype wire

/* verilog/checkpoint_ctrl.sv */
`default_nettype none

// Circular allocator for checkpoint slots.
// Saves take the tail slot, releases retire the head slot and a restore
// cuts the queue back so that the restored slot becomes the youngest
module checkpoint_ctrl (
   input  logic                     clka,
   input  logic                     arst_n,
   input  logic                     save_en,      // Branch wants a checkpoint
   input  logic                     restore_en,   // Misprediction, roll back
   input  logic                     release_en,   // Oldest branch retired
   input  rename_pkg::checkpt_ndx_t restore_ndx,  // Slot to roll back to
   output logic                     wr_en,        // Write strobe for the checkpoint RAM
   output rename_pkg::checkpt_ndx_t save_ndx,     // Slot that a save this cycle uses
   output logic                     full,
   output logic                     empty
);

   import rename_pkg::*;

   // ==================================================================
   // Queue state
   // ==================================================================

   checkpt_ndx_t head_q;                    // Oldest live slot
   checkpt_ndx_t tail_q;                    // Next slot to allocate
   checkpt_cnt_t count_q;                   // Number of live slots

   checkpt_ndx_t head_n;
   checkpt_ndx_t tail_n;
   checkpt_cnt_t count_n;
   checkpt_ndx_t keep_span;                 // Distance from head to the restored slot
   logic         rel_ok;                    // Release really retires a slot

   // Level flags come straight from the count
   assign full     = (count_q == checkpt_cnt_t'(NCHECK));
   assign empty    = (count_q == '0);
   assign save_ndx = tail_q;                // Tail shown combinationally

   // A save is granted only with room left and no restore pending.
   // A save while full just disappears
   assign wr_en  = save_en && !full && !restore_en;
   assign rel_ok = release_en && !empty;

   // Index arithmetic wraps at NCHECK by width alone
   assign keep_span = restore_ndx - head_q;

   // ==================================================================
   // Next state
   // ==================================================================

   always_comb begin
      head_n  = head_q;
      tail_n  = tail_q;
      count_n = count_q;

      if (restore_en) begin
         // Everything younger than the restored slot is dropped,
         // the restored slot itself stays live
         tail_n  = restore_ndx + checkpt_ndx_t'(1);
         count_n = checkpt_cnt_t'(keep_span) + checkpt_cnt_t'(1);
      end else if (wr_en) begin
         tail_n  = tail_q + checkpt_ndx_t'(1);      // Claim the tail slot
         count_n = count_q + checkpt_cnt_t'(1);
      end

      // Release acts after truncation, so it also works beside a restore
      if (rel_ok) begin
         head_n  = head_q + checkpt_ndx_t'(1);
         count_n = count_n - checkpt_cnt_t'(1);
      end
   end

   // ==================================================================
   // Registers
   // ==================================================================

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;                     // Starts empty
      end else begin
         head_q  <= head_n;
         tail_q  <= tail_n;
         count_q <= count_n;
      end
   end

endmodule

`default_nettype wire

/* verilog/rename_map.sv */
`default_nettype none

// Live rename map.
// Looks up both sources and the old destination mapping from the current
// map, then applies either a restore or the new destination at the edge
module rename_map (
   input  logic                    clka,
   input  logic                    arst_n,
   input  logic                    rename_en,     // An instruction is presented
   input  logic                    restore_en,    // Reload from a checkpoint
   input  rename_pkg::rename_req_t req,
   input  rename_pkg::reg_map_t    restore_map,   // Map read from the checkpoint RAM
   output rename_pkg::rename_rsp_t rsp,
   output rename_pkg::reg_map_t    next_map       // Map as it will be after this edge
);

   import rename_pkg::*;

   // ==================================================================
   // Reset value
   // ==================================================================

   // Architectural register i starts out in physical register i
   function automatic reg_map_t identity_map();
      reg_map_t m;
      for (int i = 0; i < ARCH_REGS; i++) begin
         m[i] = preg_t'(i);
      end
      return m;
   endfunction

   // ==================================================================
   // Map storage and lookup
   // ==================================================================

   reg_map_t map_q;                         // Current map, one entry per arch register
   logic     dst_wr;                        // Destination entry changes this cycle

   // Lookups read the registered map only, so a source that matches dst
   // still sees the older mapping, which is what the instruction needs
   always_comb begin
      rsp.src_a_preg = map_q[req.src_a];
      rsp.src_b_preg = map_q[req.src_b];
      rsp.old_preg   = map_q[req.dst];      // Handed back so it can be freed at retire
   end

   // A rename without a destination leaves the map alone
   assign dst_wr = rename_en && req.has_dst;

   // ==================================================================
   // Next map
   // ==================================================================

   // Restore wins over any rename in the same cycle.
   // next_map is exported every cycle, the RAM only keeps it when a save
   // is granted
   always_comb begin
      next_map = map_q;
      if (restore_en) begin
         next_map = restore_map;            // Whole map swapped in one go
      end else if (dst_wr) begin
         next_map[req.dst] = req.new_preg;  // Single entry update
      end
   end

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         map_q <= identity_map();
      end else begin
         map_q <= next_map;
      end
   end

endmodule

`default_nettype wire

/* verilog/rename_top.sv */
`default_nettype none

// Register rename block with branch checkpoints.
// The live map feeds its post-update value to the checkpoint RAM, the
// controller decides which slot gets it and restores read a slot back
module rename_top (
   input  logic                     clka,
   input  logic                     arst_n,
   input  logic                     rename_en,
   input  rename_pkg::rename_req_t  req,
   input  logic                     save_en,
   input  logic                     restore_en,
   input  logic                     release_en,
   input  rename_pkg::checkpt_ndx_t restore_ndx,
   output rename_pkg::rename_rsp_t  rsp,
   output rename_pkg::checkpt_ndx_t save_ndx,
   output logic                     full,
   output logic                     empty
);

   import rename_pkg::*;

   // ==================================================================
   // Internal wiring
   // ==================================================================

   reg_map_t next_map;                      // Map after this edge, saved on a granted save
   reg_map_t restore_map;                   // Slot contents selected by restore_ndx
   logic     wr_en;                         // Granted save

   // Live map, lookup and update
   rename_map u_map (
      .clka        (clka),
      .arst_n      (arst_n),
      .rename_en   (rename_en),
      .restore_en  (restore_en),
      .req         (req),
      .restore_map (restore_map),
      .rsp         (rsp),
      .next_map    (next_map)
   );

   // Slot allocation, the tail slot is also the RAM write address
   checkpoint_ctrl u_ctrl (
      .clka        (clka),
      .arst_n      (arst_n),
      .save_en     (save_en),
      .restore_en  (restore_en),
      .release_en  (release_en),
      .restore_ndx (restore_ndx),
      .wr_en       (wr_en),
      .save_ndx    (save_ndx),
      .full        (full),
      .empty       (empty)
   );

   // Checkpoint storage, port A saves and port B restores
   reg_map_ram u_ram (
      .clka   (clka),
      .wr_en  (wr_en),
      .wr_ndx (save_ndx),
      .wr_map (next_map),
      .rd_ndx (restore_ndx),
      .rd_map (restore_map)
   );

endmodule

`default_nettype wire

/* verif/rename_properties.sv */
`default_nettype none

// Checks on the checkpoint queue levels and the save slot of the rename block
module rename_properties (
   input logic                     clka,
   input logic                     arst_n,
   input logic                     save_en,
   input logic                     restore_en,
   input rename_pkg::checkpt_ndx_t save_ndx,
   input logic                     full,
   input logic                     empty
);

   timeunit 1ns;
   timeprecision 1ps;

   // ==================================================================
   // Queue levels
   // ==================================================================

   // Count cannot be 0 and NCHECK at once
   a_full_empty_exclusive: assert property (@(posedge clka) disable iff (!arst_n)
      !(full && empty))
      else $error("full and empty are high together");

   // Rolling back needs at least one live checkpoint
   a_restore_needs_live: assert property (@(posedge clka) disable iff (!arst_n)
      restore_en |-> !empty)
      else $error("restore issued with no live checkpoint");

   // ==================================================================
   // Save slot
   // ==================================================================

   // The tail only moves on a save or a restore
   a_save_ndx_moves: assert property (@(posedge clka) disable iff (!arst_n)
      (save_ndx != $past(save_ndx)) |-> ($past(save_en) || $past(restore_en)))
      else $error("save_ndx moved without a save or a restore");

endmodule

bind rename_top rename_properties u_props (
   .clka       (clka),
   .arst_n     (arst_n),
   .save_en    (save_en),
   .restore_en (restore_en),
   .save_ndx   (save_ndx),
   .full       (full),
   .empty      (empty)
);

`default_nettype wire

/* verif/rename_tb.sv */
`default_nettype none

// Random testbench for the rename block, checked against a model that tracks
// the live map, the saved maps and the checkpoint queue
module rename_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import rename_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 3;
   localparam int SWEEP_CYCLES = ARCH_REGS;        // One lookup per arch register after reset
   localparam int RAND_CYCLES  = 2000;
   localparam int TIMEOUT_NS   = (RESET_CYCLES + SWEEP_CYCLES + RAND_CYCLES + 100) * CLK_PERIOD;

   // Saved map together with the slot it went into
   typedef struct packed {
      checkpt_ndx_t ndx;
      reg_map_t     map;
   } saved_t;

   // ==================================================================
   // DUT and clock
   // ==================================================================

   logic         clka;
   logic         arst_n;
   logic         rename_en;
   rename_req_t  req;
   logic         save_en;
   logic         restore_en;
   logic         release_en;
   checkpt_ndx_t restore_ndx;
   rename_rsp_t  rsp;
   checkpt_ndx_t save_ndx;
   logic         full;
   logic         empty;

   reg_map_t     model_map;                        // Model of the live map
   saved_t       saved_q [$];                      // Live checkpoints, oldest first
   checkpt_ndx_t model_head;
   checkpt_ndx_t model_tail;
   int           model_count;
   integer       seed;
   int           fail_count;

   rename_top u_dut (
      .clka        (clka),
      .arst_n      (arst_n),
      .rename_en   (rename_en),
      .req         (req),
      .save_en     (save_en),
      .restore_en  (restore_en),
      .release_en  (release_en),
      .restore_ndx (restore_ndx),
      .rsp         (rsp),
      .save_ndx    (save_ndx),
      .full        (full),
      .empty       (empty)
   );

   always #(CLK_PERIOD / 2) clka = ~clka;

   // ==================================================================
   // Compare tasks
   // ==================================================================

   task automatic report_failure();
      fail_count++;
      $display("Test failed");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check_rsp(input rename_rsp_t actual, input rename_rsp_t expected);
      if (actual !== expected) begin
         $display("Fail rsp: expected 0x%h, got 0x%h", expected, actual);
         report_failure();
      end
   endtask

   task automatic check_ndx(input string name, input checkpt_ndx_t actual,
                            input checkpt_ndx_t expected);
      if (actual !== expected) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
         report_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
         report_failure();
      end
   endtask

   // ==================================================================
   // Reference model
   // ==================================================================

   task automatic reset_model();
      for (int i = 0; i < ARCH_REGS; i++) begin
         model_map[i] = preg_t'(i);                // Identity after reset
      end
      saved_q.delete();
      model_head  = '0;
      model_tail  = '0;
      model_count = 0;
   endtask

   // Lookups come from the map as it stands before the edge
   function automatic rename_rsp_t expected_rsp();
      rename_rsp_t e;
      e.src_a_preg = model_map[req.src_a];
      e.src_b_preg = model_map[req.src_b];
      e.old_preg   = model_map[req.dst];
      return e;
   endfunction

   // Applies one clock edge with the inputs that are being driven
   task automatic step_model();
      int     pos;
      saved_t entry;
      pos = -1;
      if (restore_en) begin
         for (int k = 0; k < saved_q.size(); k++) begin
            if (saved_q[k].ndx == restore_ndx) pos = k;   // Find the slot among live ones
         end
         if (pos < 0) begin
            $display("Restore was issued for a slot that the model does not hold");
            report_failure();
         end
         model_map = saved_q[pos].map;
         while (saved_q.size() > pos + 1) begin
            void'(saved_q.pop_back());             // Younger checkpoints are gone
         end
         model_tail = restore_ndx + checkpt_ndx_t'(1);
      end else begin
         if (rename_en && req.has_dst) model_map[req.dst] = req.new_preg;
         if (save_en && model_count < NCHECK) begin
            entry.ndx = model_tail;
            entry.map = model_map;                 // Saved map holds this cycle's rename
            saved_q.push_back(entry);
            model_tail = model_tail + checkpt_ndx_t'(1);
         end
      end
      // Release comes last, after any truncation, and only if the queue was not empty
      if (release_en && model_count > 0) begin
         void'(saved_q.pop_front());
         model_head = model_head + checkpt_ndx_t'(1);
      end
      model_count = saved_q.size();
   endtask

   task automatic check_outputs();
      check_rsp(rsp, expected_rsp());
      check_ndx("save_ndx", save_ndx, model_tail);
      check_flag("full", full, model_count == NCHECK);
      check_flag("empty", empty, model_count == 0);
   endtask

   // ==================================================================
   // Stimulus
   // ==================================================================

   // Plain lookup of one register pair, nothing changes
   task automatic drive_lookup(input int i);
      rename_en    = 1'b0;
      save_en      = 1'b0;
      restore_en   = 1'b0;
      release_en   = 1'b0;
      req.src_a    = arch_reg_t'(i);
      req.src_b    = arch_reg_t'(ARCH_REGS - 1 - i);
      req.dst      = arch_reg_t'(i);
      req.has_dst  = 1'b0;
      req.new_preg = '0;
   endtask

   task automatic drive_random(input int cycle);
      logic [31:0] r;
      logic [31:0] s;
      int          save_thr;
      int          rel_thr;
      int          live;
      r = $random(seed);
      s = $random(seed);
      // Blocks of 100 cycles alternate between filling and draining the queue
      if ((cycle / 100) % 2 == 0) begin
         save_thr = 115;
         rel_thr  = 26;
      end else begin
         save_thr = 38;
         rel_thr  = 102;
      end
      req.src_a    = r[4:0];
      req.src_b    = r[9:5];
      req.dst      = r[14:10];
      req.has_dst  = r[15];
      req.new_preg = r[21:16];
      rename_en    = r[22] | r[23];                // Three cycles in four
      if (r[26:24] == 3'd0) req.src_a = req.dst;   // Source equal to dst now and then
      save_en    = int'(s[7:0]) < save_thr;
      release_en = int'(s[15:8]) < rel_thr;
      live       = model_count;
      if (live > 0 && int'(s[23:16]) < 13) begin
         restore_en  = 1'b1;
         // Live slots run from the head for count slots
         restore_ndx = model_head + checkpt_ndx_t'(int'(s[31:24]) % live);
      end else begin
         restore_en  = 1'b0;
         restore_ndx = r[31:29];
      end
   endtask

   // Check where outputs are settled, then move the model across the edge
   task automatic run_cycle();
      @(negedge clka);
      check_outputs();
      @(posedge clka);
      step_model();
      #1;
   endtask

   // ==================================================================
   // Main sequence and watchdog
   // ==================================================================

   initial begin
      seed        = 44;
      fail_count  = 0;
      clka        = 1'b0;
      arst_n      = 1'b0;
      req         = '0;
      drive_lookup(0);
      restore_ndx = '0;
      reset_model();
      repeat (RESET_CYCLES) @(posedge clka);
      #1;
      arst_n = 1'b1;
      for (int i = 0; i < SWEEP_CYCLES; i++) begin
         drive_lookup(i);                          // Every entry should read back as identity
         run_cycle();
      end
      for (int c = 0; c < RAND_CYCLES; c++) begin
         drive_random(c);
         run_cycle();
      end
      if (fail_count == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1, "Errors were found");
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("The test timed out before all cycles were run");
      report_failure();
   end

endmodule

`default_nettype wire

/* project.f */
verilog/rename_pkg.sv
verilog/reg_map_ram.sv
verilog/checkpoint_ctrl.sv
verilog/rename_map.sv
verilog/rename_top.sv
verif/rename_properties.sv
verif/rename_tb.sv

/* Makefile */
# Verilator build and run of the rename block testbench

TOP = rename_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
